//--- Makefile
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= hilbertEnvelopeTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	./$(BUILD_DIR)/$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- envelopeDetect.sv
//**********************************************************************
// Envelope stage. Turns each in-phase and quadrature pair into an
// approximate magnitude and sends it out under output credits.
//**********************************************************************
`timescale 1ns/1ps
`include "hilbert_macros.svh"

module envelopeDetect
	import htPkg::*;
(
	input logic clock,
	input logic rst,
	input logic pairValid,
	output logic pairReady,
	input sampleT quadrature,
	input sampleT inPhase,
	output logic outValid,
	output envelopeT outEnvelope,
	input logic outCredit
);

	logic [$clog2(`HT_OUT_CREDITS+1)-1:0] creditCount;
	logic accept;
	envelopeT extI;
	envelopeT extQ;
	envelopeT absI;
	envelopeT absQ;
	envelopeT maxV;
	envelopeT minV;

	// A pair can only be taken while the sink has room for the result.
	assign pairReady = (creditCount != 0);
	assign accept = pairValid && pairReady;

	// The count starts full, drops on each result and climbs back on each returned credit.
	always_ff @(posedge clock) begin
		if (rst) begin
			creditCount <= `HT_OUT_CREDITS;
		end else begin
			case ({outCredit, accept})
				2'b10: if (creditCount < `HT_OUT_CREDITS) creditCount <= creditCount + 1'b1;
				2'b01: creditCount <= creditCount - 1'b1;
				default: creditCount <= creditCount;
			endcase
		end
	end

	// Sign-extend by one bit so that the magnitude of the most negative sample fits.
	assign extI = {inPhase[`HT_SAMPLE_WIDTH-1], inPhase};
	assign extQ = {quadrature[`HT_SAMPLE_WIDTH-1], quadrature};
	assign absI = extI[`HT_SAMPLE_WIDTH] ? -extI : extI;
	assign absQ = extQ[`HT_SAMPLE_WIDTH] ? -extQ : extQ;
	assign maxV = (absI > absQ) ? absI : absQ;
	assign minV = (absI > absQ) ? absQ : absI;

	// Max plus half of min, truncated, lands in the output register one cycle after acceptance.
	always_ff @(posedge clock) begin
		if (rst) begin
			outValid <= 1'b0;
		end else begin
			outValid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			outEnvelope <= maxV + (minV >> 1);
		end
	end

endmodule

//--- flist.f
+incdir+.
htPkg.sv
htCoeffSetup.sv
htFirFilter.sv
envelopeDetect.sv
hilbertEnvelope.sv
hilbertEnvelope_chk.sv
tbClock.sv
hilbertEnvelopeTb.sv

//--- hilbertEnvelope.sv
//**********************************************************************
// Top level of the envelope detector. Samples arrive and envelopes leave
// under credit flow control. The inner blocks are joined by wires only.
//**********************************************************************
`timescale 1ns/1ps

module hilbertEnvelope
	import htPkg::*;
(
	input logic clock,
	input logic rst,
	input logic inValid,
	input sampleT inSample,
	output logic inCredit,
	output logic outValid,
	output envelopeT outEnvelope,
	input logic outCredit
);

	logic coeffEnable;
	logic coeffSetFlag;
	coeffT coefficientOut;
	logic pairValid;
	logic pairReady;
	sampleT quadrature;
	sampleT inPhase;

	// Streams the fixed taps once after reset.
	htCoeffSetup coeffSetup (
		.clock(clock),
		.rst(rst),
		.enable(coeffEnable),
		.coeffSetFlag(coeffSetFlag),
		.coefficientOut(coefficientOut)
	);

	// Filters each sample into a quadrature and in-phase pair.
	htFirFilter firFilter (
		.clock(clock),
		.rst(rst),
		.coeffEnable(coeffEnable),
		.coeffSetFlag(coeffSetFlag),
		.coefficientOut(coefficientOut),
		.inValid(inValid),
		.inSample(inSample),
		.inCredit(inCredit),
		.pairValid(pairValid),
		.pairReady(pairReady),
		.quadrature(quadrature),
		.inPhase(inPhase)
	);

	// Turns each pair into a magnitude for the sink.
	envelopeDetect envelope (
		.clock(clock),
		.rst(rst),
		.pairValid(pairValid),
		.pairReady(pairReady),
		.quadrature(quadrature),
		.inPhase(inPhase),
		.outValid(outValid),
		.outEnvelope(outEnvelope),
		.outCredit(outCredit)
	);

endmodule

//--- hilbertEnvelopeTb.sv
//**********************************************************************
// Testbench for the envelope detector. It feeds samples under input
// credits, acts as the credit sink and checks each envelope against a model.
//**********************************************************************
`timescale 1ns/1ps
`include "hilbert_macros.svh"

module hilbertEnvelopeTb
	import htPkg::*;
();

	localparam int maxSample = (1 << (`HT_SAMPLE_WIDTH - 1)) - 1;
	localparam int minSample = -maxSample - 1;
	// Sample count of all tests, the credit test counted at its cap of 12.
	localparam int totalSamples = 28 + 40 + 16 + 12 + 81;
	localparam int cycleLimit = totalSamples * (`HT_LENGTH + 4) + 200;

	logic clock;
	logic rst;
	logic inValid;
	sampleT inSample;
	logic inCredit;
	logic outValid;
	envelopeT outEnvelope;
	logic outCredit;

	// Hilbert taps scaled by 100000, odd taps zero and antisymmetric about tap 13.
	int coeffTable [`HT_LENGTH] = '{-775, 0, -1582, 0, -3114, 0, -5642, 0, -10043, 0,
		-19511, 0, -63075, 0, 63075, 0, 19511, 0, 10043, 0, 5642, 0, 3114, 0, 1582, 0, 775};
	// Model delay line. Slot k holds x[n-k] and starts at zero.
	int window [`HT_LENGTH] = '{default: 0};
	int expected [$];
	logic [31:0] lfsr = 32'h8be4;
	string testName = "reset";
	int srcCredits = `HT_IN_CREDITS;
	int creditsBack = 0;
	int heldCredits = 0;
	int creditDelay = 0;
	int stallCycles = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int checksAtStart = 0;
	int errorsAtStart = 0;
	int cycleCount = 0;

	tbClock clockGen (
		.clock(clock),
		.rst(rst)
	);

	hilbertEnvelope uut (
		.clock(clock),
		.rst(rst),
		.inValid(inValid),
		.inSample(inSample),
		.inCredit(inCredit),
		.outValid(outValid),
		.outEnvelope(outEnvelope),
		.outCredit(outCredit)
	);

	bind hilbertEnvelope hilbertEnvelope_chk chk (
		.clock(clock),
		.rst(rst),
		.inValid(inValid),
		.inCredit(inCredit),
		.outValid(outValid),
		.outCredit(outCredit)
	);

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One LFSR step for every bit taken.
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrNext(lfsr);
			value = {value[30:0], lfsr[31]};
		end
		return value;
	endfunction

	// Shift the sample into the model and queue the envelope it should produce.
	task automatic pushModel(input sampleT s);
		longint acc;
		longint q;
		int magI;
		int magQ;
		acc = 0;
		for (int k = `HT_LENGTH - 1; k > 0; k--) begin
			window[k] = window[k-1];
		end
		window[0] = s;
		for (int k = 0; k < `HT_LENGTH; k++) begin
			acc += longint'(coeffTable[k]) * window[k];
		end
		// Arithmetic shift floors, then the quadrature clips to the sample range.
		q = acc >>> `HT_SCALE_SHIFT;
		if (q > maxSample) begin
			q = maxSample;
		end else if (q < minSample) begin
			q = minSample;
		end
		magI = (window[`HT_CENTRE] < 0) ? -window[`HT_CENTRE] : window[`HT_CENTRE];
		magQ = (q < 0) ? -int'(q) : int'(q);
		expected.push_back((magI > magQ) ? magI + magQ / 2 : magQ + magI / 2);
	endtask

	// Advance one clock. Checks the output and plays the sink, which holds
	// its credits during a stall and otherwise returns them after a short random wait.
	task automatic cycle();
		int want;
		@(posedge clock);
		inValid <= 1'b0;
		outCredit <= 1'b0;
		if (inCredit) begin
			srcCredits++;
			creditsBack++;
		end
		if (outValid) begin
			assert (expected.size() != 0) else begin
				$display("Envelope %0d arrived in test %s with none expected", outEnvelope, testName);
				errors++;
			end
			if (expected.size() != 0) begin
				want = expected.pop_front();
				checks++;
				assert (outEnvelope == want) else begin
					$display("FAIL %s expected %0d actual %0d", testName, want, outEnvelope);
					errors++;
				end
			end
			heldCredits++;
		end
		if (stallCycles > 0) begin
			stallCycles--;
		end else if (heldCredits > 0) begin
			if (creditDelay == 0) begin
				outCredit <= 1'b1;
				heldCredits--;
				creditDelay = randBits(3);
			end else begin
				creditDelay--;
			end
		end
	endtask

	task automatic driveSample(input sampleT s);
		inValid <= 1'b1;
		inSample <= s;
		srcCredits--;
		pushModel(s);
	endtask

	// Waits for a free input credit, so this blocks while the FIFO is full.
	task automatic sendSample(input sampleT s);
		cycle();
		while (srcCredits == 0) begin
			cycle();
		end
		driveSample(s);
	endtask

	task automatic startTest(input string name);
		testName = name;
		checksAtStart = checks;
		errorsAtStart = errors;
	endtask

	// All queued envelopes have to come out before the test ends.
	task automatic finishTest();
		while (expected.size() != 0) begin
			cycle();
		end
		$display("%s: %0d envelopes checked, %0d errors", testName,
			checks - checksAtStart, errors - errorsAtStart);
		tests++;
	endtask

	// Stall the sink and keep offering samples whenever the source holds a credit.
	// The DUT may pop only what is in flight plus what its output credits cover.
	task automatic runCreditStall();
		int creditsBefore;
		int fed;
		creditsBefore = creditsBack;
		fed = 0;
		stallCycles = 3 * (`HT_LENGTH + 4);
		repeat (3 * (`HT_LENGTH + 4)) begin
			cycle();
			if (srcCredits > 0 && fed < 12) begin
				driveSample(sampleT'(randBits(16)));
				fed++;
			end
		end
		assert (creditsBack - creditsBefore <= `HT_IN_CREDITS + 1) else begin
			$display("Input credits kept returning during the output stall, %0d in all",
				creditsBack - creditsBefore);
			errors++;
		end
		assert (srcCredits == 0) else begin
			$display("Source still had %0d input credits with the output stalled", srcCredits);
			errors++;
		end
	endtask

	initial begin
		inValid = 1'b0;
		inSample = '0;
		outCredit = 1'b0;
		cycle();
		while (rst) begin
			cycle();
		end

		startTest("impulse");
		sendSample(sampleT'(16384));
		repeat (`HT_LENGTH) sendSample('0);
		finishTest();

		startTest("random");
		repeat (40) sendSample(sampleT'(randBits(16)));
		finishTest();

		// Two long stretches without credits, each starting a block of eight samples.
		// Each stretch outlasts two envelopes, so the DUT runs out of output credits.
		startTest("backPressure");
		for (int i = 0; i < 16; i++) begin
			if (i % 8 == 0) begin
				stallCycles = 3 * (`HT_LENGTH + 4);
			end
			sendSample(sampleT'(randBits(16)));
		end
		finishTest();

		startTest("inputCredits");
		runCreditStall();
		finishTest();

		// Full-scale square wave, half a period per filter length, so each edge clips Q.
		startTest("saturation");
		for (int i = 0; i < 3 * `HT_LENGTH; i++) begin
			sendSample(sampleT'(((i / `HT_LENGTH) % 2 == 0) ? maxSample : minSample));
		end
		finishTest();

		// Any stray envelope after the last test shows up here.
		repeat (`HT_LENGTH + 4) cycle();
		$display("%0d tests, %0d envelopes checked, %0d errors, %0d protocol violations",
			tests, checks, errors, uut.chk.violations);
		if (errors == 0 && uut.chk.violations == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog on the total run length.
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			$display("Timeout after %0d cycles, the DUT stopped delivering envelopes", cycleLimit);
			$display("Checks failed");
			$finish;
		end
	end

endmodule

//--- hilbertEnvelope_chk.sv
//**********************************************************************
// Protocol checker for the envelope detector ports. It is bound to the
// top level from the testbench and tracks both credit loops itself.
//**********************************************************************
`timescale 1ns/1ps
`include "hilbert_macros.svh"

module hilbertEnvelope_chk (
	input logic clock,
	input logic rst,
	input logic inValid,
	input logic inCredit,
	input logic outValid,
	input logic outCredit
);

	// Samples taken by the DUT whose credit has not come back yet.
	int inFlight;
	// Credits the DUT holds for the sink, as seen from the ports.
	int outCredits;
	int sinceReset;
	logic sawInput;
	// Number of failed assertions, read by the testbench at the end.
	int violations = 0;

	always_ff @(posedge clock) begin
		if (rst) begin
			inFlight <= 0;
			outCredits <= `HT_OUT_CREDITS;
			sinceReset <= 0;
			sawInput <= 1'b0;
		end else begin
			inFlight <= inFlight + int'(inValid) - int'(inCredit);
			outCredits <= outCredits - int'(outValid) + int'(outCredit);
			// Saturate once the earliest legal output time has passed.
			if (sinceReset < `HT_LENGTH) begin
				sinceReset <= sinceReset + 1;
			end
			if (inValid) begin
				sawInput <= 1'b1;
			end
		end
	end

	// Nothing may leave the DUT before the first sample has gone in.
	quietUntilInput: assert property (@(posedge clock) disable iff (rst)
		!sawInput |-> !outValid && !inCredit)
		else begin
			$error("output or input credit seen before any sample was sent");
			violations++;
		end

	// The coefficient load alone takes longer than this.
	noEarlyOutput: assert property (@(posedge clock) disable iff (rst)
		outValid |-> sinceReset >= `HT_LENGTH)
		else begin
			$error("envelope came out too soon after reset");
			violations++;
		end

	outNeedsCredit: assert property (@(posedge clock) disable iff (rst)
		outValid |-> outCredits > 0)
		else begin
			$error("envelope sent while the sink had no free credit");
			violations++;
		end

	// Every returned input credit must belong to a sample that was accepted.
	creditsMatchSamples: assert property (@(posedge clock) disable iff (rst)
		inCredit |-> inFlight > 0)
		else begin
			$error("input credit returned with no sample outstanding");
			violations++;
		end

	sourceHasCredit: assert property (@(posedge clock) disable iff (rst)
		inValid |-> inFlight < `HT_IN_CREDITS)
		else begin
			$error("sample sent while the source had no input credit");
			violations++;
		end

endmodule

//--- hilbert_macros.svh
//**********************************************************************
// Size and depth constants for the Hilbert envelope detector.
// Include this header wherever a width, tap count or credit depth is needed.
//**********************************************************************
`ifndef HILBERT_MACROS_SVH
`define HILBERT_MACROS_SVH

// Number of filter taps, fixed by the coefficient table.
`define HT_LENGTH 27
// Group delay of the filter in samples, which is also the centre tap.
`define HT_CENTRE 13

// Word widths of the datapath.
`define HT_COEFF_WIDTH 18
`define HT_SAMPLE_WIDTH 16
`define HT_ACC_WIDTH 40

// Coefficients carry a gain of about 100000, and this shift removes most of it.
`define HT_SCALE_SHIFT 17

// Depth of the input FIFO and of the sink's buffer.
`define HT_IN_CREDITS 4
`define HT_OUT_CREDITS 2

`endif

//--- htCoeffSetup.sv
//**********************************************************************
// Coefficient source for the Hilbert FIR. While enable is high it streams
// the 27 scaled taps in index order and flags the last one.
//**********************************************************************
`timescale 1ns/1ps
`include "hilbert_macros.svh"

module htCoeffSetup
	import htPkg::*;
(
	input logic clock,
	input logic rst,
	input logic enable,
	output logic coeffSetFlag,
	output coeffT coefficientOut
);

	// Index of the next coefficient to send.
	logic [$clog2(`HT_LENGTH)-1:0] coeffCounter;

	// Fixed table from an equiripple Hilbert design, scaled by 100000.
	// The filter is antisymmetric, so odd taps are zero and the first half mirrors
	// the second half with the sign flipped.
	function automatic coeffT romCoeff(input logic [$clog2(`HT_LENGTH)-1:0] idx);
		case (idx)
			0: romCoeff = coeffT'(-775);
			2: romCoeff = coeffT'(-1582);
			4: romCoeff = coeffT'(-3114);
			6: romCoeff = coeffT'(-5642);
			8: romCoeff = coeffT'(-10043);
			10: romCoeff = coeffT'(-19511);
			12: romCoeff = coeffT'(-63075);
			14: romCoeff = coeffT'(63075);
			16: romCoeff = coeffT'(19511);
			18: romCoeff = coeffT'(10043);
			20: romCoeff = coeffT'(5642);
			22: romCoeff = coeffT'(3114);
			24: romCoeff = coeffT'(1582);
			26: romCoeff = coeffT'(775);
			default: romCoeff = '0;
		endcase
	endfunction

	// Coefficient i leaves the register i+1 cycles after enable rises.
	// The counter parks on the last index, so the flag stays up until enable drops.
	always_ff @(posedge clock) begin
		if (rst || !enable) begin
			coeffCounter <= '0;
			coeffSetFlag <= 1'b0;
			coefficientOut <= '0;
		end else begin
			coefficientOut <= romCoeff(coeffCounter);
			if (coeffCounter == `HT_LENGTH - 1) begin
				coeffSetFlag <= 1'b1;
			end else begin
				coeffCounter <= coeffCounter + 1'b1;
				coeffSetFlag <= 1'b0;
			end
		end
	end

endmodule

//--- htFirFilter.sv
//**********************************************************************
// Serial 27-tap Hilbert FIR. Loads its taps after reset, takes samples
// through a credit FIFO and offers one quadrature and in-phase pair per sample.
//**********************************************************************
`timescale 1ns/1ps
`include "hilbert_macros.svh"

module htFirFilter
	import htPkg::*;
(
	input logic clock,
	input logic rst,
	output logic coeffEnable,
	input logic coeffSetFlag,
	input coeffT coefficientOut,
	input logic inValid,
	input sampleT inSample,
	output logic inCredit,
	output logic pairValid,
	input logic pairReady,
	output sampleT quadrature,
	output sampleT inPhase
);

	coeffT coeffTaps [`HT_LENGTH];
	sampleT delayLine [`HT_LENGTH];
	sampleT fifoMem [`HT_IN_CREDITS];
	logic [$clog2(`HT_IN_CREDITS)-1:0] wrPtr;
	logic [$clog2(`HT_IN_CREDITS)-1:0] rdPtr;
	logic [$clog2(`HT_IN_CREDITS):0] fifoCount;
	logic [$clog2(`HT_LENGTH)-1:0] tapIdx;
	logic macBusy;
	logic macDone;
	logic pop;
	accT acc;
	accT product;
	accT accShifted;
	sampleT satQ;

	// Taps shift in from the top, so after the final coefficient c[0] sits in slot 0.
	// Anything shifted in before coefficient 0 falls out the bottom.
	always_ff @(posedge clock) begin
		if (coeffEnable) begin
			for (int k = 0; k < `HT_LENGTH - 1; k++) begin
				coeffTaps[k] <= coeffTaps[k+1];
			end
			coeffTaps[`HT_LENGTH-1] <= coefficientOut;
		end
	end

	// Loading runs from reset until the source flags its last coefficient.
	always_ff @(posedge clock) begin
		if (rst) begin
			coeffEnable <= 1'b1;
		end else if (coeffSetFlag) begin
			coeffEnable <= 1'b0;
		end
	end

	// A new sample enters the delay line only when the MAC and the pair register are idle.
	assign pop = !coeffEnable && (fifoCount != 0) && !macBusy && !macDone && !pairValid;

	// The upstream source never sends without a credit, so the FIFO cannot overflow.
	always_ff @(posedge clock) begin
		if (inValid) begin
			fifoMem[wrPtr] <= inSample;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoCount <= '0;
			inCredit <= 1'b0;
		end else begin
			if (inValid) begin
				wrPtr <= (wrPtr == `HT_IN_CREDITS - 1) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == `HT_IN_CREDITS - 1) ? '0 : rdPtr + 1'b1;
			end
			fifoCount <= fifoCount + inValid - pop;
			// Each popped sample frees one FIFO slot and returns one credit.
			inCredit <= pop;
		end
	end

	// Slot k holds x[n-k]. It starts cleared so that earlier samples count as zero.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < `HT_LENGTH; k++) begin
				delayLine[k] <= '0;
			end
		end else if (pop) begin
			for (int k = `HT_LENGTH - 1; k > 0; k--) begin
				delayLine[k] <= delayLine[k-1];
			end
			delayLine[0] <= fifoMem[rdPtr];
		end
	end

	// One tap product per cycle, both operands sign-extended to the accumulator width.
	assign product = accT'(coeffTaps[tapIdx]) * accT'(delayLine[tapIdx]);

	// The MAC runs for HT_LENGTH cycles after a pop and the pair is offered one cycle later.
	always_ff @(posedge clock) begin
		if (rst) begin
			macBusy <= 1'b0;
			macDone <= 1'b0;
			tapIdx <= '0;
			pairValid <= 1'b0;
		end else begin
			macDone <= 1'b0;
			if (pop) begin
				macBusy <= 1'b1;
				tapIdx <= '0;
			end else if (macBusy) begin
				if (tapIdx == `HT_LENGTH - 1) begin
					macBusy <= 1'b0;
					macDone <= 1'b1;
				end else begin
					tapIdx <= tapIdx + 1'b1;
				end
			end
			if (macDone) begin
				pairValid <= 1'b1;
			end else if (pairValid && pairReady) begin
				pairValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			acc <= '0;
		end else if (macBusy) begin
			acc <= acc + product;
		end
	end

	// Remove the coefficient gain with an arithmetic shift, which truncates toward minus infinity.
	assign accShifted = acc >>> `HT_SCALE_SHIFT;

	// The value fits when every bit above the sample sign bit matches it.
	always_comb begin
		if ((&accShifted[`HT_ACC_WIDTH-1:`HT_SAMPLE_WIDTH-1]) ||
			!(|accShifted[`HT_ACC_WIDTH-1:`HT_SAMPLE_WIDTH-1])) begin
			satQ = accShifted[`HT_SAMPLE_WIDTH-1:0];
		end else if (accShifted[`HT_ACC_WIDTH-1]) begin
			satQ = {1'b1, {(`HT_SAMPLE_WIDTH-1){1'b0}}};
		end else begin
			satQ = {1'b0, {(`HT_SAMPLE_WIDTH-1){1'b1}}};
		end
	end

	// The pair stays put while pairValid waits for pairReady.
	always_ff @(posedge clock) begin
		if (macDone) begin
			quadrature <= satQ;
			inPhase <= delayLine[`HT_CENTRE];
		end
	end

endmodule

//--- htPkg.sv
//**********************************************************************
// Shared datapath types for the Hilbert envelope detector.
// Modules take these types by a wildcard import of the package.
//**********************************************************************
`include "hilbert_macros.svh"

package htPkg;

	// One signed input or output sample.
	typedef logic signed [`HT_SAMPLE_WIDTH-1:0] sampleT;

	// One signed, scaled filter coefficient.
	typedef logic signed [`HT_COEFF_WIDTH-1:0] coeffT;

	// Accumulator wide enough for the full sum of 27 products.
	typedef logic signed [`HT_ACC_WIDTH-1:0] accT;

	// Unsigned magnitude. One extra bit holds max plus half of min.
	typedef logic [`HT_SAMPLE_WIDTH:0] envelopeT;

endpackage

//--- tbClock.sv
//**********************************************************************
// Testbench clock and reset. Gives an 8 ns clock and holds rst high
// for the first two rising edges.
//**********************************************************************
`timescale 1ns/1ps

module tbClock (
	output logic clock,
	output logic rst
);

	// Reset drops on the second rising edge, so the DUT sees it for two cycles.
	initial begin
		clock = 1'b0;
		rst = 1'b1;
		repeat (2) @(posedge clock);
		rst <= 1'b0;
	end

	// Half period of 4 ns.
	always #4 clock = ~clock;

endmodule
